/* source/rs_cfg.svh */
`ifndef RS_CFG_SVH
`define RS_CFG_SVH

//////////////////////////////////////////////////
// datapath

// operand and result width
`define RS_XLEN 32

// rob tag width, tag 0 is the register file
`define RS_TAG_BITS 5

//////////////////////////////////////////////////
// station size

// entry count, 2 to 16
`define RS_ENTRIES 8

`endif

/* source/rs_pkg.sv */
`include "rs_cfg.svh"

package rs_pkg;

    // major opcodes of the integer alu class
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // one instruction word, two decodings
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } rv_inst_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // source operand as held in an entry
    typedef struct packed {
        logic [`RS_TAG_BITS-1:0] tag;
        logic [`RS_XLEN-1:0]     value;
        logic                    ready;
    } operand_t;

endpackage

/* source/rs_interfaces.sv */
`timescale 1ns/1ps

`include "rs_cfg.svh"

//////////////////////////////////////////////////
// dispatch to entries

interface rs_alloc_if;
    // one-hot, at most one bit per cycle
    logic [`RS_ENTRIES-1:0] alloc;
    rs_pkg::alu_op_t        op;
    logic [`RS_TAG_BITS-1:0] dest;
    rs_pkg::operand_t       opnd1;
    rs_pkg::operand_t       opnd2;
    // one bit driven by each entry
    logic [`RS_ENTRIES-1:0] busy;

    modport dispatcher (
        output alloc, op, dest, opnd1, opnd2,
        input  busy
    );

    modport slot (
        input  alloc, op, dest, opnd1, opnd2,
        output busy
    );
endinterface

//////////////////////////////////////////////////
// entries to arbiter

interface rs_issue_if;
    logic [`RS_ENTRIES-1:0]  request;
    logic [`RS_TAG_BITS-1:0] tag [`RS_ENTRIES];
    logic [`RS_XLEN-1:0]     result [`RS_ENTRIES];
    // one-hot, subset of request
    logic [`RS_ENTRIES-1:0]  grant;

    modport slot (
        output request, tag, result,
        input  grant
    );

    modport arbiter (
        input  request, tag, result,
        output grant
    );

    modport monitor (
        input grant
    );
endinterface

/* source/rs_alu.sv */
`timescale 1ns/1ps

module rs_alu #(
    parameter int WIDTH = 32
) (
    input  rs_pkg::alu_op_t    op,
    input  logic [WIDTH-1:0]   a,
    input  logic [WIDTH-1:0]   b,
    output logic [WIDTH-1:0]   y
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // rv32 shift amount
    assign shamt       = b[4:0];
    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb begin
        case (op)
            rs_pkg::ALU_ADD:  y = a + b;
            rs_pkg::ALU_SUB:  y = a - b;
            rs_pkg::ALU_SLL:  y = a << shamt;
            rs_pkg::ALU_SLT:  y = {{(WIDTH-1){1'b0}}, lt_signed};
            rs_pkg::ALU_SLTU: y = {{(WIDTH-1){1'b0}}, lt_unsigned};
            rs_pkg::ALU_XOR:  y = a ^ b;
            rs_pkg::ALU_SRL:  y = a >> shamt;
            rs_pkg::ALU_SRA:  y = $unsigned($signed(a) >>> shamt);
            rs_pkg::ALU_OR:   y = a | b;
            rs_pkg::ALU_AND:  y = a & b;
            default:          y = '0;
        endcase
    end

endmodule

/* source/rs_entry.sv */
`timescale 1ns/1ps

`include "rs_cfg.svh"

module rs_entry #(
    parameter int INDEX = 0
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    squash,
    input  logic                    cdb_valid,
    input  logic [`RS_TAG_BITS-1:0] cdb_tag,
    input  logic [`RS_XLEN-1:0]     cdb_value,
    rs_alloc_if.slot                alloc,
    rs_issue_if.slot                issue
);

    logic                    busy_q;
    rs_pkg::alu_op_t         op_q;
    logic [`RS_TAG_BITS-1:0] dest_q;
    rs_pkg::operand_t        opnd1_q;
    rs_pkg::operand_t        opnd2_q;
    logic                    load;
    logic                    wake1;
    logic                    wake2;

    assign load = alloc.alloc[INDEX];

    // waiting operand sees its producer on the bus
    assign wake1 = busy_q && !opnd1_q.ready && cdb_valid && (cdb_tag == opnd1_q.tag);
    assign wake2 = busy_q && !opnd2_q.ready && cdb_valid && (cdb_tag == opnd2_q.tag);

    //////////////////////////////////////////////////
    // occupancy

    // a new allocation wins over the grant of the old one
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            busy_q <= 1'b0;
        end else if (load) begin
            busy_q <= 1'b1;
        end else if (issue.grant[INDEX]) begin
            busy_q <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // operand storage and wakeup

    always_ff @(posedge clock) begin
        if (load) begin
            op_q    <= alloc.op;
            dest_q  <= alloc.dest;
            opnd1_q <= alloc.opnd1;
            opnd2_q <= alloc.opnd2;
        end else begin
            if (wake1) begin
                opnd1_q.value <= cdb_value;
                opnd1_q.ready <= 1'b1;
            end
            if (wake2) begin
                opnd2_q.value <= cdb_value;
                opnd2_q.ready <= 1'b1;
            end
        end
    end

    rs_alu #(
        .WIDTH (`RS_XLEN)
    ) u_alu (
        .op (op_q),
        .a  (opnd1_q.value),
        .b  (opnd2_q.value),
        .y  (issue.result[INDEX])
    );

    assign alloc.busy[INDEX]    = busy_q;
    assign issue.request[INDEX] = busy_q && opnd1_q.ready && opnd2_q.ready;
    assign issue.tag[INDEX]     = dest_q;

endmodule

/* source/rs_dispatch.sv */
`timescale 1ns/1ps

`include "rs_cfg.svh"

module rs_dispatch (
    input  logic                    dispatch_valid,
    input  rs_pkg::rv_inst_t        inst,
    input  logic [`RS_TAG_BITS-1:0] dest_tag,
    input  logic [`RS_TAG_BITS-1:0] src1_tag,
    input  logic [`RS_XLEN-1:0]     src1_value,
    input  logic                    src1_ready,
    input  logic [`RS_TAG_BITS-1:0] src2_tag,
    input  logic [`RS_XLEN-1:0]     src2_value,
    input  logic                    src2_ready,
    input  logic                    cdb_valid,
    input  logic [`RS_TAG_BITS-1:0] cdb_tag,
    input  logic [`RS_XLEN-1:0]     cdb_value,
    rs_alloc_if.dispatcher          alloc,
    rs_issue_if.monitor             issue,
    output logic                    full
);

    logic [`RS_ENTRIES-1:0] free;
    logic [`RS_ENTRIES-1:0] first_free;
    logic                   is_r;
    logic                   is_imm;
    logic                   alt;
    logic [2:0]             funct3;
    logic [`RS_XLEN-1:0]    imm_sext;

    // tag zero and same-cycle cdb broadcast both count as ready
    function automatic rs_pkg::operand_t resolve(
        input logic [`RS_TAG_BITS-1:0] tag,
        input logic [`RS_XLEN-1:0]     value,
        input logic                    ready,
        input logic                    bus_valid,
        input logic [`RS_TAG_BITS-1:0] bus_tag,
        input logic [`RS_XLEN-1:0]     bus_value
    );
        rs_pkg::operand_t o;
        o.tag   = tag;
        o.value = value;
        o.ready = ready || (tag == '0);
        if (!o.ready && bus_valid && (bus_tag == tag)) begin
            o.value = bus_value;
            o.ready = 1'b1;
        end
        return o;
    endfunction

    //////////////////////////////////////////////////
    // decode

    assign is_r     = (inst.r.opcode == rs_pkg::OPCODE_OP);
    assign is_imm   = (inst.i.opcode == rs_pkg::OPCODE_OP_IMM);
    assign funct3   = inst.r.funct3;
    // bit 30 selects sub, sra and srai
    assign alt      = inst.r.funct7[5];
    assign imm_sext = {{(`RS_XLEN-12){inst.i.imm[11]}}, inst.i.imm};

    always_comb begin
        case (funct3)
            3'd0:    alloc.op = (is_r && alt) ? rs_pkg::ALU_SUB : rs_pkg::ALU_ADD;
            3'd1:    alloc.op = rs_pkg::ALU_SLL;
            3'd2:    alloc.op = rs_pkg::ALU_SLT;
            3'd3:    alloc.op = rs_pkg::ALU_SLTU;
            3'd4:    alloc.op = rs_pkg::ALU_XOR;
            3'd5:    alloc.op = alt ? rs_pkg::ALU_SRA : rs_pkg::ALU_SRL;
            3'd6:    alloc.op = rs_pkg::ALU_OR;
            default: alloc.op = rs_pkg::ALU_AND;
        endcase
    end

    //////////////////////////////////////////////////
    // operands

    assign alloc.dest  = dest_tag;
    assign alloc.opnd1 = resolve(src1_tag, src1_value, src1_ready,
                                 cdb_valid, cdb_tag, cdb_value);

    always_comb begin
        if (is_imm) begin
            alloc.opnd2.tag   = '0;
            alloc.opnd2.value = imm_sext;
            alloc.opnd2.ready = 1'b1;
        end else begin
            alloc.opnd2 = resolve(src2_tag, src2_value, src2_ready,
                                  cdb_valid, cdb_tag, cdb_value);
        end
    end

    //////////////////////////////////////////////////
    // allocation

    // an entry granted this cycle frees at the same edge
    assign free = ~alloc.busy | issue.grant;
    assign full = ~|free;

    always_comb begin
        first_free = '0;
        for (int k = 0; k < `RS_ENTRIES; k++) begin
            if (free[k] && (first_free == '0)) begin
                first_free[k] = 1'b1;
            end
        end
    end

    // first_free is all zero when full
    assign alloc.alloc = dispatch_valid ? first_free : '0;

endmodule

/* source/cdb_arbiter.sv */
`timescale 1ns/1ps

`include "rs_cfg.svh"

module cdb_arbiter (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    squash,
    rs_issue_if.arbiter             issue,
    output logic                    result_valid,
    output logic [`RS_TAG_BITS-1:0] result_tag,
    output logic [`RS_XLEN-1:0]     result_value
);

    localparam int IDX_BITS = $clog2(`RS_ENTRIES);

    logic [IDX_BITS-1:0] sel;
    logic                any;

    // fixed priority, entry 0 highest
    always_comb begin
        issue.grant = '0;
        sel         = '0;
        any         = 1'b0;
        for (int k = 0; k < `RS_ENTRIES; k++) begin
            if (issue.request[k] && !any) begin
                any            = 1'b1;
                sel            = IDX_BITS'(k);
                issue.grant[k] = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // result register

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= any;
        end
    end

    // loads at the edge that frees the granted entry
    always_ff @(posedge clock) begin
        if (any) begin
            result_tag   <= issue.tag[sel];
            result_value <= issue.result[sel];
        end
    end

endmodule

/* source/reservation_station.sv */
`timescale 1ns/1ps

`include "rs_cfg.svh"

module reservation_station (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    squash,

    // dispatch
    input  logic                    dispatch_valid,
    input  rs_pkg::rv_inst_t        inst,
    input  logic [`RS_TAG_BITS-1:0] dest_tag,
    input  logic [`RS_TAG_BITS-1:0] src1_tag,
    input  logic [`RS_XLEN-1:0]     src1_value,
    input  logic                    src1_ready,
    input  logic [`RS_TAG_BITS-1:0] src2_tag,
    input  logic [`RS_XLEN-1:0]     src2_value,
    input  logic                    src2_ready,

    // common data bus
    input  logic                    cdb_valid,
    input  logic [`RS_TAG_BITS-1:0] cdb_tag,
    input  logic [`RS_XLEN-1:0]     cdb_value,

    output logic                    full,
    output logic                    result_valid,
    output logic [`RS_TAG_BITS-1:0] result_tag,
    output logic [`RS_XLEN-1:0]     result_value
);

    rs_alloc_if alloc_bus ();
    rs_issue_if issue_bus ();

    rs_dispatch u_dispatch (
        .dispatch_valid (dispatch_valid),
        .inst           (inst),
        .dest_tag       (dest_tag),
        .src1_tag       (src1_tag),
        .src1_value     (src1_value),
        .src1_ready     (src1_ready),
        .src2_tag       (src2_tag),
        .src2_value     (src2_value),
        .src2_ready     (src2_ready),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .alloc          (alloc_bus),
        .issue          (issue_bus),
        .full           (full)
    );

    // one entry per slot, each with its own alu
    for (genvar k = 0; k < `RS_ENTRIES; k++) begin : g_entry
        rs_entry #(
            .INDEX (k)
        ) u_entry (
            .clock     (clock),
            .reset     (reset),
            .squash    (squash),
            .cdb_valid (cdb_valid),
            .cdb_tag   (cdb_tag),
            .cdb_value (cdb_value),
            .alloc     (alloc_bus),
            .issue     (issue_bus)
        );
    end

    cdb_arbiter u_arbiter (
        .clock        (clock),
        .reset        (reset),
        .squash       (squash),
        .issue        (issue_bus),
        .result_valid (result_valid),
        .result_tag   (result_tag),
        .result_value (result_value)
    );

endmodule

/* dv/tb_reservation_station.sv */
`timescale 1ns/1ps

`include "rs_cfg.svh"

module tb_reservation_station;

    localparam int MAX_RECORDS = 64;
    localparam int WORDS       = 10;
    localparam int NUM_TAGS    = 1 << `RS_TAG_BITS;

    logic                    clock;
    logic                    reset;
    logic                    squash;
    logic                    dispatch_valid;
    logic [31:0]             inst;
    logic [`RS_TAG_BITS-1:0] dest_tag;
    logic [`RS_TAG_BITS-1:0] src1_tag;
    logic [`RS_XLEN-1:0]     src1_value;
    logic                    src1_ready;
    logic [`RS_TAG_BITS-1:0] src2_tag;
    logic [`RS_XLEN-1:0]     src2_value;
    logic                    src2_ready;
    logic                    cdb_valid;
    logic [`RS_TAG_BITS-1:0] cdb_tag;
    logic [`RS_XLEN-1:0]     cdb_value;
    logic                    full;
    logic                    result_valid;
    logic [`RS_TAG_BITS-1:0] result_tag;
    logic [`RS_XLEN-1:0]     result_value;

    // records of ten words each, see the pattern file header
    logic [31:0]             pat [0:MAX_RECORDS*WORDS-1];

    // scoreboard by tag
    logic [`RS_XLEN-1:0]     exp_value [NUM_TAGS];
    logic [`RS_TAG_BITS-1:0] wait1 [NUM_TAGS];
    logic [`RS_TAG_BITS-1:0] wait2 [NUM_TAGS];
    bit                      expected [NUM_TAGS];
    bit                      seen [NUM_TAGS];
    bit                      squashed [NUM_TAGS];
    bit                      sent [NUM_TAGS];

    logic                    inject_valid;
    logic [`RS_TAG_BITS-1:0] inject_tag;
    logic [`RS_XLEN-1:0]     inject_value;

    int num_records;
    int dispatched;
    int received;
    int errors;
    int test_errors;
    int tests_run;
    int seed;
    int cur_test;

    reservation_station uut (
        .clock          (clock),
        .reset          (reset),
        .squash         (squash),
        .dispatch_valid (dispatch_valid),
        .inst           (inst),
        .dest_tag       (dest_tag),
        .src1_tag       (src1_tag),
        .src1_value     (src1_value),
        .src1_ready     (src1_ready),
        .src2_tag       (src2_tag),
        .src2_value     (src2_value),
        .src2_ready     (src2_ready),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .full           (full),
        .result_valid   (result_valid),
        .result_tag     (result_tag),
        .result_value   (result_value)
    );

    always #5 clock = ~clock;

    task automatic note_failure();
        errors++;
        test_errors++;
    endtask

    function automatic string test_name(input int t);
        case (t)
            1:       return "ready operands";
            2:       return "wakeup";
            3:       return "full";
            default: return "squash";
        endcase
    endfunction

    //////////////////////////////////////////////////
    // result monitor and cdb feedback

    always @(negedge clock) begin
        if (!reset && result_valid) begin
            if (squashed[result_tag]) begin
                $display("squashed tag %0d was issued at %0t", result_tag, $time);
                note_failure();
            end else if (!expected[result_tag] || seen[result_tag]) begin
                $display("tag %0d issued unexpectedly or twice at %0t", result_tag, $time);
                note_failure();
            end else begin
                if (result_value !== exp_value[result_tag]) begin
                    $display("** Error at %0t: tag %0d result %h, expected %h",
                             $time, result_tag, result_value, exp_value[result_tag]);
                    note_failure();
                end
                if ((wait1[result_tag] != 0 && !seen[wait1[result_tag]]) ||
                    (wait2[result_tag] != 0 && !seen[wait2[result_tag]])) begin
                    $display("tag %0d completed before its producer", result_tag);
                    note_failure();
                end
            end
            seen[result_tag] = 1'b1;
            received++;
        end
    end

    // results go back on the bus one edge later, as in the core
    always @(posedge clock) begin
        if (result_valid) begin
            sent[result_tag] = 1'b1;
        end
        cdb_valid <= result_valid | inject_valid;
        cdb_tag   <= result_valid ? result_tag : inject_tag;
        cdb_value <= result_valid ? result_value : inject_value;
    end

    //////////////////////////////////////////////////
    // stimulus

    task automatic dispatch_record(input int r);
        int                      b;
        int                      gap;
        logic [`RS_TAG_BITS-1:0] d;
        logic [`RS_TAG_BITS-1:0] t1;
        logic [`RS_TAG_BITS-1:0] t2;
        logic [`RS_XLEN-1:0]     v1;
        logic [`RS_XLEN-1:0]     v2;
        logic                    r1;
        logic                    r2;
        b  = r * WORDS;
        d  = pat[b+2][`RS_TAG_BITS-1:0];
        t1 = pat[b+3][`RS_TAG_BITS-1:0];
        v1 = pat[b+4];
        r1 = pat[b+5][0];
        t2 = pat[b+6][`RS_TAG_BITS-1:0];
        v2 = pat[b+7];
        r2 = pat[b+8][0];
        @(negedge clock);
        while (full !== 1'b0) begin
            @(negedge clock);
        end
        // producer already left the bus, so the rob supplies it
        if (!r1 && t1 != 0 && sent[t1]) begin
            v1 = exp_value[t1];
            r1 = 1'b1;
        end
        if (!r2 && t2 != 0 && sent[t2]) begin
            v2 = exp_value[t2];
            r2 = 1'b1;
        end
        if (pat[b][3:0] == 4'd1) begin
            squashed[d] = 1'b1;
        end else begin
            expected[d]  = 1'b1;
            exp_value[d] = pat[b+9];
            wait1[d]     = pat[b+5][0] ? '0 : t1;
            wait2[d]     = (pat[b+8][0] || pat[b+1][6:0] == 7'h13) ? '0 : t2;
        end
        @(posedge clock);
        dispatch_valid <= 1'b1;
        inst           <= pat[b+1];
        dest_tag       <= d;
        src1_tag       <= t1;
        src1_value     <= v1;
        src1_ready     <= r1;
        src2_tag       <= t2;
        src2_value     <= v2;
        src2_ready     <= r2;
        @(posedge clock);
        dispatch_valid <= 1'b0;
        if (pat[b][3:0] == 4'd0) begin
            dispatched++;
        end
        gap = {$random(seed)} % 4;
        repeat (gap) @(posedge clock);
    endtask

    task automatic inject_record(input int r);
        int b;
        b = r * WORDS;
        @(negedge clock);
        if (full !== 1'b1) begin
            $display("full not raised with every entry waiting at %0t", $time);
            note_failure();
        end
        exp_value[pat[b+2][`RS_TAG_BITS-1:0]] = pat[b+9];
        seen[pat[b+2][`RS_TAG_BITS-1:0]]      = 1'b1;
        @(posedge clock);
        inject_valid <= 1'b1;
        inject_tag   <= pat[b+2][`RS_TAG_BITS-1:0];
        inject_value <= pat[b+9];
        @(posedge clock);
        inject_valid <= 1'b0;
        sent[pat[b+2][`RS_TAG_BITS-1:0]] = 1'b1;
    endtask

    // repeat a waiting record until every entry is taken
    task automatic fill_station(input int r);
        @(negedge clock);
        while (full !== 1'b1) begin
            dispatch_record(r);
            @(negedge clock);
        end
    endtask

    task automatic pulse_squash();
        @(posedge clock);
        squash <= 1'b1;
        @(posedge clock);
        squash <= 1'b0;
        @(negedge clock);
        if (full !== 1'b0) begin
            $display("station not empty after squash at %0t", $time);
            note_failure();
        end
    endtask

    task automatic finish_test(input int t);
        while (dispatched != received) begin
            @(negedge clock);
        end
        @(negedge clock);
        if (full !== 1'b0) begin
            $display("full still high after all results drained");
            note_failure();
        end
        $display("test %0d %s: %0d errors", t, test_name(t), test_errors);
        test_errors = 0;
        tests_run++;
    endtask

    initial begin
        wait (reset === 1'b0);
        #((num_records * 40 + 200) * 10);
        $display("watchdog expired, results still outstanding");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        squash         = 1'b0;
        dispatch_valid = 1'b0;
        inst           = '0;
        dest_tag       = '0;
        src1_tag       = '0;
        src1_value     = '0;
        src1_ready     = 1'b0;
        src2_tag       = '0;
        src2_value     = '0;
        src2_ready     = 1'b0;
        cdb_valid      = 1'b0;
        cdb_tag        = '0;
        cdb_value      = '0;
        inject_valid   = 1'b0;
        inject_tag     = '0;
        inject_value   = '0;
        seed           = 30673;
        $readmemh("dv/rs_patterns.mem", pat);
        // every record carries a nonzero test number
        while (num_records < MAX_RECORDS && pat[num_records*WORDS][7:4] != 4'd0) begin
            num_records++;
        end
        if (num_records == 0) begin
            $display("no records read from the pattern file");
            note_failure();
        end

        for (int i = 0; i < 16; i++) begin
            @(negedge clock);
            if (result_valid !== 1'b0 || full !== 1'b0) begin
                $display("outputs not low during reset at %0t", $time);
                note_failure();
            end
        end
        @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        if (result_valid !== 1'b0 || full !== 1'b0) begin
            $display("outputs not low right after reset");
            note_failure();
        end
        $display("test 5 reset state: %0d errors", test_errors);
        test_errors = 0;
        tests_run++;

        cur_test = int'(pat[0][7:4]);
        for (int r = 0; r < num_records; r++) begin
            if (int'(pat[r*WORDS][7:4]) != cur_test) begin
                finish_test(cur_test);
                cur_test = int'(pat[r*WORDS][7:4]);
            end
            case (pat[r*WORDS][3:0])
                4'd2: inject_record(r);
                4'd3: begin
                    fill_station(r - 1);
                    pulse_squash();
                end
                default: dispatch_record(r);
            endcase
        end
        finish_test(cur_test);

        $display("%0d tests run, %0d checks failed", tests_run, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* dv/rs_patterns.mem */
// ctrl = test number and mode (0 dispatch, 1 dispatch then squash, 2 cdb inject, 3 squash)
// ctrl inst dest src1_tag src1_value src1_ready src2_tag src2_value src2_ready expected
10 00000033 01 00 00000010 0 00 00000020 1 00000030
10 40000033 02 1e 00000005 1 00 00000007 1 fffffffe
10 00001033 03 00 00000003 1 00 00000024 1 00000030
10 00002033 04 00 ffffffff 1 00 00000001 1 00000001
10 00003033 05 00 ffffffff 1 00 00000001 1 00000000
10 00004033 06 00 f0f0f0f0 1 00 0ff00ff0 1 ff00ff00
10 00005033 07 00 80000000 1 00 00000004 1 08000000
10 40005033 08 00 80000000 1 00 00000004 1 f8000000
10 00006033 09 00 12340000 1 00 00005678 1 12345678
10 00007033 0a 00 ffff0000 1 00 12345678 1 12340000
10 ffb00013 0b 00 0000000a 1 00 00000000 0 00000005
10 40405013 0c 00 f0000000 1 00 00000000 0 ff000000
// wakeup chain
20 00000033 0d 00 00000001 1 00 00000002 1 00000003
20 00000033 0e 0d 00000000 0 00 0000000a 1 0000000d
20 40000033 0f 0e 00000000 0 0d 00000000 0 0000000a
// eight waiters on tag 10, then its value on the cdb
30 00000033 11 10 00000000 0 00 00000001 1 00000101
30 00000033 12 10 00000000 0 00 00000002 1 00000102
30 00000033 13 10 00000000 0 00 00000003 1 00000103
30 00000033 14 10 00000000 0 00 00000004 1 00000104
30 00000033 15 10 00000000 0 00 00000005 1 00000105
30 00000033 16 10 00000000 0 00 00000006 1 00000106
30 00000033 17 10 00000000 0 00 00000007 1 00000107
30 00000033 18 10 00000000 0 00 00000008 1 00000108
32 00000000 10 00 00000000 0 00 00000000 0 00000100
// waiters on tag 19, which never comes
41 00000033 1a 19 00000000 0 00 00000001 1 00000000
41 00000033 1b 19 00000000 0 00 00000002 1 00000000
41 00000033 1c 19 00000000 0 00 00000003 1 00000000
41 00000033 1d 19 00000000 0 00 00000004 1 00000000
43 00000000 00 00 00000000 0 00 00000000 0 00000000
40 00007033 1e 00 ffff0000 1 00 0f0f0f0f 1 0f0f0000
40 00002033 1f 00 00000001 1 00 ffffffff 1 00000000

/* build.f */
+incdir+source
source/rs_pkg.sv
source/rs_interfaces.sv
source/rs_alu.sv
source/rs_entry.sv
source/rs_dispatch.sv
source/cdb_arbiter.sv
source/reservation_station.sv
dv/tb_reservation_station.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= tb_reservation_station
RTL_TOP   ?= reservation_station
FILELIST  ?= build.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall -Isource --top-module $(RTL_TOP) \
		$(filter-out dv/%,$(filter %.sv,$(shell cat $(FILELIST))))

clean:
	rm -rf obj_dir $(LOG)
